// File: hw/floo_axi_pkg.sv
////////////////////////////////////////////////////////////
// AXI4 field widths and response encoding for the manager
// side of the network interface. Shared by RTL and testbench
////////////////////////////////////////////////////////////

package floo_axi_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned AxiIdWidth   = 4;
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;
  localparam int unsigned AxiLenWidth  = 8;

  ////////////////////////////////////////////////////////////
  // Channel field types
  ////////////////////////////////////////////////////////////

  typedef logic [AxiIdWidth-1:0]   axi_id_t;
  typedef logic [AxiAddrWidth-1:0] axi_addr_t;
  typedef logic [AxiDataWidth-1:0] axi_data_t;
  typedef logic [AxiStrbWidth-1:0] axi_strb_t;

  // Beats per burst minus one
  typedef logic [AxiLenWidth-1:0]  axi_len_t;

  // B and R response codes
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespExOkay = 2'b01,
    RespSlvErr = 2'b10,
    RespDecErr = 2'b11
  } axi_resp_e;

endpackage

// File: hw/floo_noc_pkg.sv
////////////////////////////////////////////////////////////
// NoC side definitions: node coordinates, channel tags,
// address map rules and the flit formats of both links
////////////////////////////////////////////////////////////

package floo_noc_pkg;

  import floo_axi_pkg::*;

  // Mesh coordinates of a node
  typedef struct packed {
    logic [2:0] x;
    logic [2:0] y;
  } id_t;

  // AXI channel carried by a flit
  typedef enum logic [2:0] {
    AxiAw = 3'd0,
    AxiW  = 3'd1,
    AxiAr = 3'd2,
    AxiB  = 3'd3,
    AxiR  = 3'd4
  } axi_ch_e;

  // One address map entry, end_addr is exclusive
  typedef struct packed {
    id_t       idx;
    axi_addr_t start_addr;
    axi_addr_t end_addr;
  } sam_rule_t;

  typedef struct packed {
    id_t     dst_id;
    id_t     src_id;
    axi_ch_e axi_ch;
    logic    last;
  } floo_hdr_t;

  ////////////////////////////////////////////////////////////
  // Payload layouts, placed in the low bits of the flit
  ////////////////////////////////////////////////////////////

  localparam int unsigned ReqPayloadWidth = 80;
  localparam int unsigned RspPayloadWidth = 39;

  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } floo_ax_pld_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } floo_w_pld_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_e resp;
  } floo_b_pld_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_e resp;
    logic      last;
  } floo_r_pld_t;

  typedef struct packed {
    floo_hdr_t                  hdr;
    logic [ReqPayloadWidth-1:0] payload;
  } floo_req_flit_t;

  typedef struct packed {
    floo_hdr_t                  hdr;
    logic [RspPayloadWidth-1:0] payload;
  } floo_rsp_flit_t;

endpackage

// File: hw/floo_addr_translation.sv
////////////////////////////////////////////////////////////
// System address map lookup. Turns a request address into
// the node ID of the first matching rule, node zero if none
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_addr_translation
  import floo_axi_pkg::*;
  import floo_noc_pkg::*;
#(
  parameter int unsigned                     NumSamRules = 4,
  parameter sam_rule_t [NumSamRules-1:0]     Sam         = '0
) (
  input  axi_addr_t addr_i,
  output id_t       dst_id_o
);

  logic [NumSamRules-1:0] rule_hit;

  ////////////////////////////////////////////////////////////
  // Range compare per rule
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumSamRules; i++) begin : gen_rule_match
    // Half-open interval [start, end)
    assign rule_hit[i] = (addr_i >= Sam[i].start_addr) &&
                         (addr_i <  Sam[i].end_addr);
  end

  ////////////////////////////////////////////////////////////
  // Priority select
  ////////////////////////////////////////////////////////////

  // Walk from the top so the lowest matching index is applied last
  always_comb begin
    dst_id_o = '0;
    for (int i = int'(NumSamRules) - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        dst_id_o = Sam[i].idx;
      end
    end
  end

endmodule

// File: hw/floo_req_packer.sv
////////////////////////////////////////////////////////////
// Packs AXI AW, W and AR beats into request flits. AW and W
// share one arbiter input; W is offered only after its AW
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_req_packer
  import floo_axi_pkg::*;
  import floo_noc_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  id_t            id_i,
  // AW channel
  input  logic           aw_valid_i,
  output logic           aw_ready_o,
  input  axi_id_t        aw_id_i,
  input  axi_addr_t      aw_addr_i,
  input  axi_len_t       aw_len_i,
  input  id_t            aw_dst_i,
  // W channel
  input  logic           w_valid_i,
  output logic           w_ready_o,
  input  axi_data_t      w_data_i,
  input  axi_strb_t      w_strb_i,
  input  logic           w_last_i,
  // AR channel
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  input  axi_id_t        ar_id_i,
  input  axi_addr_t      ar_addr_i,
  input  axi_len_t       ar_len_i,
  input  id_t            ar_dst_i,
  // Arbiter side
  output logic           wr_req_o,
  input  logic           wr_gnt_i,
  output floo_req_flit_t wr_flit_o,
  output logic           rd_req_o,
  input  logic           rd_gnt_i,
  output floo_req_flit_t rd_flit_o
);

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e      aw_w_sel_q, aw_w_sel_d;
  id_t            aw_dst_q;
  floo_req_flit_t aw_flit, w_flit, ar_flit;
  floo_ax_pld_t   aw_pld, ar_pld;
  floo_w_pld_t    w_pld;

  ////////////////////////////////////////////////////////////
  // Flit construction
  ////////////////////////////////////////////////////////////

  assign aw_pld = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i};
  assign ar_pld = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i};
  assign w_pld  = '{data: w_data_i, strb: w_strb_i, last: w_last_i};

  // AW opens a write packet, so last stays clear
  always_comb begin
    aw_flit = '0;
    aw_flit.hdr.dst_id = aw_dst_i;
    aw_flit.hdr.src_id = id_i;
    aw_flit.hdr.axi_ch = AxiAw;
    aw_flit.hdr.last   = 1'b0;
    aw_flit.payload[$bits(floo_ax_pld_t)-1:0] = aw_pld;
  end

  // W beats follow their AW to the same node
  always_comb begin
    w_flit = '0;
    w_flit.hdr.dst_id = aw_dst_q;
    w_flit.hdr.src_id = id_i;
    w_flit.hdr.axi_ch = AxiW;
    w_flit.hdr.last   = w_last_i;
    w_flit.payload[$bits(floo_w_pld_t)-1:0] = w_pld;
  end

  // A read request is a single-flit packet
  always_comb begin
    ar_flit = '0;
    ar_flit.hdr.dst_id = ar_dst_i;
    ar_flit.hdr.src_id = id_i;
    ar_flit.hdr.axi_ch = AxiAr;
    ar_flit.hdr.last   = 1'b1;
    ar_flit.payload[$bits(floo_ax_pld_t)-1:0] = ar_pld;
  end

  ////////////////////////////////////////////////////////////
  // AW/W selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    aw_w_sel_d = aw_w_sel_q;
    if (aw_valid_i && aw_ready_o) begin
      aw_w_sel_d = SelW;
    end
    if (w_valid_i && w_ready_o && w_last_i) begin
      aw_w_sel_d = SelAw;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_w_sel_q <= SelAw;
    end else begin
      aw_w_sel_q <= aw_w_sel_d;
    end
  end

  // Destination of the burst in flight
  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      aw_dst_q <= aw_dst_i;
    end
  end

  assign wr_req_o  = (aw_w_sel_q == SelAw) ? aw_valid_i : w_valid_i;
  assign wr_flit_o = (aw_w_sel_q == SelAw) ? aw_flit : w_flit;
  assign rd_req_o  = ar_valid_i;
  assign rd_flit_o = ar_flit;

  assign aw_ready_o = wr_gnt_i && (aw_w_sel_q == SelAw);
  assign w_ready_o  = wr_gnt_i && (aw_w_sel_q == SelW);
  assign ar_ready_o = rd_gnt_i;

endmodule

// File: hw/floo_wormhole_arbiter.sv
////////////////////////////////////////////////////////////
// Two-input round-robin arbiter for the request link. A
// granted input keeps the link until its flit with last set
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_wormhole_arbiter
  import floo_noc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic           [1:0] valid_i,
  input  floo_req_flit_t [1:0] data_i,
  output logic           [1:0] ready_o,
  output logic                 valid_o,
  output floo_req_flit_t       data_o,
  input  logic                 ready_i
);

  logic lock_q, lock_d;
  logic hold_q, hold_d;
  logic prio_q, prio_d;
  logic sel;

  ////////////////////////////////////////////////////////////
  // Input selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      sel = hold_q;
    end else if (valid_i[prio_q]) begin
      sel = prio_q;
    end else begin
      sel = ~prio_q;
    end
  end

  assign valid_o = valid_i[sel];
  assign data_o  = data_i[sel];

  // Grant only goes to the selected input on a transfer
  assign ready_o = (valid_o && ready_i) ? (2'b01 << sel) : 2'b00;

  ////////////////////////////////////////////////////////////
  // Lock and priority update
  ////////////////////////////////////////////////////////////

  always_comb begin
    lock_d = lock_q;
    hold_d = hold_q;
    prio_d = prio_q;
    if (valid_o) begin
      hold_d = sel;
      if (!ready_i) begin
        // A stalled flit keeps the link so floo_req_o stays stable
        lock_d = 1'b1;
      end else if (data_o.hdr.last) begin
        lock_d = 1'b0;
        prio_d = ~sel;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= 1'b0;
      hold_q <= 1'b0;
      prio_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
      hold_q <= hold_d;
      prio_q <= prio_d;
    end
  end

endmodule

// File: hw/floo_rsp_unpacker.sv
////////////////////////////////////////////////////////////
// Steers response flits from the inbound link onto AXI B
// or R, depending on the channel tag in the header
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_rsp_unpacker
  import floo_axi_pkg::*;
  import floo_noc_pkg::*;
(
  input  logic           flit_valid_i,
  output logic           flit_ready_o,
  input  floo_rsp_flit_t flit_i,
  // B channel
  output logic           b_valid_o,
  input  logic           b_ready_i,
  output axi_id_t        b_id_o,
  output axi_resp_e      b_resp_o,
  // R channel
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output axi_id_t        r_id_o,
  output axi_data_t      r_data_o,
  output axi_resp_e      r_resp_o,
  output logic           r_last_o
);

  logic        is_b, is_r;
  floo_b_pld_t b_pld;
  floo_r_pld_t r_pld;

  assign is_b = (flit_i.hdr.axi_ch == AxiB);
  assign is_r = (flit_i.hdr.axi_ch == AxiR);

  assign b_pld = flit_i.payload[$bits(floo_b_pld_t)-1:0];
  assign r_pld = flit_i.payload[$bits(floo_r_pld_t)-1:0];

  assign b_valid_o = flit_valid_i && is_b;
  assign r_valid_o = flit_valid_i && is_r;

  // Flits of any other channel are drained so the link cannot hang
  assign flit_ready_o = is_b ? b_ready_i :
                        is_r ? r_ready_i : 1'b1;

  assign b_id_o   = b_pld.id;
  assign b_resp_o = b_pld.resp;

  assign r_id_o   = r_pld.id;
  assign r_data_o = r_pld.data;
  assign r_resp_o = r_pld.resp;
  assign r_last_o = r_pld.last;

endmodule

// File: hw/floo_axi_chimney.sv
////////////////////////////////////////////////////////////
// Manager-side AXI4 network interface. Requests leave as
// flits on one link, responses return as AXI B and R beats
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module floo_axi_chimney
  import floo_axi_pkg::*;
  import floo_noc_pkg::*;
#(
  parameter int unsigned                 NumSamRules = 4,
  parameter sam_rule_t [NumSamRules-1:0] Sam         = '0
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  id_t            id_i,
  // AXI AW
  input  logic           aw_valid_i,
  output logic           aw_ready_o,
  input  axi_id_t        aw_id_i,
  input  axi_addr_t      aw_addr_i,
  input  axi_len_t       aw_len_i,
  // AXI W
  input  logic           w_valid_i,
  output logic           w_ready_o,
  input  axi_data_t      w_data_i,
  input  axi_strb_t      w_strb_i,
  input  logic           w_last_i,
  // AXI AR
  input  logic           ar_valid_i,
  output logic           ar_ready_o,
  input  axi_id_t        ar_id_i,
  input  axi_addr_t      ar_addr_i,
  input  axi_len_t       ar_len_i,
  // AXI B
  output logic           b_valid_o,
  input  logic           b_ready_i,
  output axi_id_t        b_id_o,
  output axi_resp_e      b_resp_o,
  // AXI R
  output logic           r_valid_o,
  input  logic           r_ready_i,
  output axi_id_t        r_id_o,
  output axi_data_t      r_data_o,
  output axi_resp_e      r_resp_o,
  output logic           r_last_o,
  // Outbound request link
  output logic           floo_req_valid_o,
  input  logic           floo_req_ready_i,
  output floo_req_flit_t floo_req_o,
  // Inbound response link
  input  logic           floo_rsp_valid_i,
  output logic           floo_rsp_ready_o,
  input  floo_rsp_flit_t floo_rsp_i
);

  id_t                  aw_dst, ar_dst;
  // Index 0 is the AW/W path, index 1 the AR path
  logic           [1:0] arb_req;
  logic           [1:0] arb_gnt;
  floo_req_flit_t [1:0] arb_flit;

  ////////////////////////////////////////////////////////////
  // Address translation
  ////////////////////////////////////////////////////////////

  floo_addr_translation #(
    .NumSamRules ( NumSamRules ),
    .Sam         ( Sam         )
  ) i_aw_translation (
    .addr_i   ( aw_addr_i ),
    .dst_id_o ( aw_dst    )
  );

  floo_addr_translation #(
    .NumSamRules ( NumSamRules ),
    .Sam         ( Sam         )
  ) i_ar_translation (
    .addr_i   ( ar_addr_i ),
    .dst_id_o ( ar_dst    )
  );

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////

  floo_req_packer i_req_packer (
    .clk_i      ( clk_i       ),
    .arst_n_i   ( arst_n_i    ),
    .id_i       ( id_i        ),
    .aw_valid_i ( aw_valid_i  ),
    .aw_ready_o ( aw_ready_o  ),
    .aw_id_i    ( aw_id_i     ),
    .aw_addr_i  ( aw_addr_i   ),
    .aw_len_i   ( aw_len_i    ),
    .aw_dst_i   ( aw_dst      ),
    .w_valid_i  ( w_valid_i   ),
    .w_ready_o  ( w_ready_o   ),
    .w_data_i   ( w_data_i    ),
    .w_strb_i   ( w_strb_i    ),
    .w_last_i   ( w_last_i    ),
    .ar_valid_i ( ar_valid_i  ),
    .ar_ready_o ( ar_ready_o  ),
    .ar_id_i    ( ar_id_i     ),
    .ar_addr_i  ( ar_addr_i   ),
    .ar_len_i   ( ar_len_i    ),
    .ar_dst_i   ( ar_dst      ),
    .wr_req_o   ( arb_req[0]  ),
    .wr_gnt_i   ( arb_gnt[0]  ),
    .wr_flit_o  ( arb_flit[0] ),
    .rd_req_o   ( arb_req[1]  ),
    .rd_gnt_i   ( arb_gnt[1]  ),
    .rd_flit_o  ( arb_flit[1] )
  );

  floo_wormhole_arbiter i_req_arbiter (
    .clk_i    ( clk_i            ),
    .arst_n_i ( arst_n_i         ),
    .valid_i  ( arb_req          ),
    .data_i   ( arb_flit         ),
    .ready_o  ( arb_gnt          ),
    .valid_o  ( floo_req_valid_o ),
    .data_o   ( floo_req_o       ),
    .ready_i  ( floo_req_ready_i )
  );

  ////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////

  floo_rsp_unpacker i_rsp_unpacker (
    .flit_valid_i ( floo_rsp_valid_i ),
    .flit_ready_o ( floo_rsp_ready_o ),
    .flit_i       ( floo_rsp_i       ),
    .b_valid_o    ( b_valid_o        ),
    .b_ready_i    ( b_ready_i        ),
    .b_id_o       ( b_id_o           ),
    .b_resp_o     ( b_resp_o         ),
    .r_valid_o    ( r_valid_o        ),
    .r_ready_i    ( r_ready_i        ),
    .r_id_o       ( r_id_o           ),
    .r_data_o     ( r_data_o         ),
    .r_resp_o     ( r_resp_o         ),
    .r_last_o     ( r_last_o         )
  );

endmodule

// File: tb/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// Testbench clock and reset. 20 ns clock, reset held low
// for a set number of cycles, released on a falling edge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_checks.svh
////////////////////////////////////////////////////////////
// Compare tasks and error counters for the chimney
// testbench. Included inside the testbench top module
////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned err_cnt = 0;
int unsigned chk_cnt = 0;

task automatic note_failure(input string msg);
  err_cnt++;
  $display("%s", msg);
endtask

task automatic check_req_flit(input string name, input floo_req_flit_t exp,
                              input floo_req_flit_t act);
  chk_cnt++;
  if (act !== exp) begin
    note_failure($sformatf("error %s: expected flit %h, actual flit %h", name, exp, act));
  end
endtask

task automatic check_b(input string name, input axi_id_t exp_id, input axi_resp_e exp_resp,
                       input axi_id_t act_id, input axi_resp_e act_resp);
  chk_cnt++;
  if (act_id !== exp_id || act_resp !== exp_resp) begin
    note_failure($sformatf("error %s: expected B id %h resp %0d, actual B id %h resp %0d",
                           name, exp_id, exp_resp, act_id, act_resp));
  end
endtask

task automatic check_r(input string name, input axi_id_t exp_id, input axi_data_t exp_data,
                       input axi_resp_e exp_resp, input logic exp_last,
                       input axi_id_t act_id, input axi_data_t act_data,
                       input axi_resp_e act_resp, input logic act_last);
  chk_cnt++;
  if (act_id !== exp_id || act_data !== exp_data || act_resp !== exp_resp ||
      act_last !== exp_last) begin
    note_failure($sformatf("error %s: expected R %h/%h/%0d/%b, actual R %h/%h/%0d/%b", name,
                           exp_id, exp_data, exp_resp, exp_last,
                           act_id, act_data, act_resp, act_last));
  end
endtask

`endif

// File: tb/tb_floo_axi_chimney.sv
////////////////////////////////////////////////////////////
// Directed testbench for the manager-side AXI chimney.
// Drives AXI requests and response flits, checks the flits
// on the request link and the returned B and R beats
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_floo_axi_chimney
  import floo_axi_pkg::*;
  import floo_noc_pkg::*;
();

  localparam int unsigned ResetCycles = 10;
  localparam int unsigned NumRules    = 4;
  localparam int unsigned LongBurst   = 8;
  localparam int unsigned ShortBurst  = 4;
  localparam int unsigned NumRsp      = 8;
  localparam int unsigned MaxStall    = 9;
  localparam logic [31:0] Seed        = 32'hf2d;
  localparam logic [31:0] LfsrTaps    = 32'h8020_0003;
  localparam id_t         TbId        = 6'o23;
  localparam axi_addr_t   RegionBase  = 32'h4000_0000;
  localparam axi_addr_t   RegionSpan  = 32'h0000_4000;

  // Handshakes per test, each costs about three cycles
  localparam int unsigned TestBeats = (3 + LongBurst) + 1 + (NumRules + 1) +
                                      (4 + ShortBurst) + (1 + ShortBurst) + 4 * NumRsp;
  localparam int unsigned TimeoutCycles = ResetCycles + 3 * TestBeats + MaxStall + 100;

  // Node of each 4 KiB region, coordinates as octal x/y
  localparam id_t [NumRules-1:0] NodeOf = {6'o74, 6'o56, 6'o31, 6'o12};

  localparam sam_rule_t [NumRules-1:0] TbSam = {
    NodeOf[3], RegionBase + 32'h3000, RegionBase + 32'h4000,
    NodeOf[2], RegionBase + 32'h2000, RegionBase + 32'h3000,
    NodeOf[1], RegionBase + 32'h1000, RegionBase + 32'h2000,
    NodeOf[0], RegionBase,            RegionBase + 32'h1000
  };

  logic clk_i, arst_n_i;
  id_t  id_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i, ar_valid_i, ar_ready_o;
  axi_id_t aw_id_i, ar_id_i, b_id_o, r_id_o;
  axi_addr_t aw_addr_i, ar_addr_i;
  axi_len_t aw_len_i, ar_len_i;
  axi_data_t w_data_i, r_data_o;
  axi_strb_t w_strb_i;
  logic b_valid_o, b_ready_i, r_valid_o, r_ready_i, r_last_o;
  axi_resp_e b_resp_o, r_resp_o;
  logic floo_req_valid_o, floo_req_ready_i, floo_rsp_valid_i, floo_rsp_ready_o;
  floo_req_flit_t floo_req_o;
  floo_rsp_flit_t floo_rsp_i;

  floo_req_flit_t exp_q[$];
  floo_req_flit_t seen_q[$];
  logic [31:0] lfsr_state = Seed;
  int unsigned cycle_cnt = 0;

  `include "tb_checks.svh"

  tb_clk_gen #(.ResetCycles(ResetCycles)) i_clk_gen (.clk_o(clk_i), .arst_n_o(arst_n_i));

  floo_axi_chimney #(
    .NumSamRules ( NumRules ),
    .Sam         ( TbSam    )
  ) dut (.*);

  ////////////////////////////////////////////////////////////
  // Link monitor and watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (arst_n_i && floo_req_valid_o && floo_req_ready_i) begin
      seen_q.push_back(floo_req_o);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and expected values
  ////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
        lfsr_state = lfsr_state ^ LfsrTaps;
      end
      r = {r[30:0], b};
    end
    return r;
  endfunction

  function automatic axi_id_t rand_id();
    logic [31:0] r;
    r = rand_bits(AxiIdWidth);
    return r[AxiIdWidth-1:0];
  endfunction

  function automatic axi_resp_e rand_resp();
    logic [31:0] r;
    r = rand_bits(2);
    return axi_resp_e'(r[1:0]);
  endfunction

  function automatic axi_addr_t rand_region_addr();
    logic [31:0] r;
    r = rand_bits(14);
    return RegionBase + {18'd0, r[13:0]};
  endfunction

  // Regions are contiguous from RegionBase, 4 KiB each
  function automatic id_t expected_node(input axi_addr_t addr);
    axi_addr_t off;
    off = addr - RegionBase;
    if (addr >= RegionBase && off < RegionSpan) begin
      return NodeOf[off[13:12]];
    end
    return '0;
  endfunction

  function automatic floo_req_flit_t ax_flit(input axi_ch_e ch, input id_t dst,
                                             input axi_id_t id, input axi_addr_t addr,
                                             input axi_len_t len);
    floo_req_flit_t f;
    f = '0;
    f.hdr.dst_id = dst;
    f.hdr.src_id = TbId;
    f.hdr.axi_ch = ch;
    f.hdr.last   = (ch == AxiAr);
    f.payload[43:0] = {id, addr, len};
    return f;
  endfunction

  function automatic floo_req_flit_t w_flit(input id_t dst, input axi_data_t data,
                                            input axi_strb_t strb, input logic last);
    floo_req_flit_t f;
    f = '0;
    f.hdr.dst_id = dst;
    f.hdr.src_id = TbId;
    f.hdr.axi_ch = AxiW;
    f.hdr.last   = last;
    f.payload[36:0] = {data, strb, last};
    return f;
  endfunction

  ////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////

  task automatic send_ar(input axi_id_t id, input axi_addr_t addr, input axi_len_t len);
    @(negedge clk_i);
    ar_valid_i = 1'b1;
    ar_id_i    = id;
    ar_addr_i  = addr;
    ar_len_i   = len;
    @(posedge clk_i);
    while (!ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    ar_valid_i = 1'b0;
  endtask

  // AW then its W beats, expected flits queued as they are driven
  task automatic do_write(input axi_addr_t addr, input int unsigned beats);
    axi_id_t     id;
    id_t         dst;
    logic [31:0] r;
    id  = rand_id();
    dst = expected_node(addr);
    exp_q.push_back(ax_flit(AxiAw, dst, id, addr, axi_len_t'(beats - 1)));
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_id_i    = id;
    aw_addr_i  = addr;
    aw_len_i   = axi_len_t'(beats - 1);
    @(posedge clk_i);
    while (!aw_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    // AW address is don't-care once accepted, W keeps the stored node
    aw_addr_i  = '0;
    for (int unsigned i = 0; i < beats; i++) begin
      w_data_i = rand_bits(32);
      r = rand_bits(4);
      w_strb_i  = r[3:0];
      w_last_i  = (i == beats - 1);
      w_valid_i = 1'b1;
      exp_q.push_back(w_flit(dst, w_data_i, w_strb_i, w_last_i));
      @(posedge clk_i);
      while (!w_ready_o) @(posedge clk_i);
      @(negedge clk_i);
    end
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
  endtask

  task automatic compare_req_flits(input string name);
    if (seen_q.size() != exp_q.size()) begin
      note_failure($sformatf("error %s: expected %0d flits, actual %0d flits",
                             name, exp_q.size(), seen_q.size()));
    end
    while (exp_q.size() > 0 && seen_q.size() > 0) begin
      check_req_flit(name, exp_q.pop_front(), seen_q.pop_front());
    end
    exp_q.delete();
    seen_q.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_write_burst();
    do_write(rand_region_addr(), LongBurst);
    do_write(rand_region_addr(), 1);
    compare_req_flits("test_write_burst");
  endtask

  task automatic test_read();
    axi_id_t     id;
    axi_addr_t   addr;
    logic [31:0] r;
    id   = rand_id();
    addr = rand_region_addr();
    r    = rand_bits(8);
    exp_q.push_back(ax_flit(AxiAr, expected_node(addr), id, addr, r[7:0]));
    send_ar(id, addr, r[7:0]);
    compare_req_flits("test_read");
  endtask

  task automatic test_addr_map();
    axi_id_t     id;
    axi_addr_t   addr;
    logic [31:0] r;
    for (int i = 0; i < NumRules; i++) begin
      r    = rand_bits(12);
      addr = RegionBase + {18'd0, 2'(i), r[11:0]};
      id   = rand_id();
      exp_q.push_back(ax_flit(AxiAr, NodeOf[i], id, addr, 8'd0));
      send_ar(id, addr, 8'd0);
    end
    // Outside every rule, falls back to node zero
    r    = rand_bits(16);
    addr = 32'h8000_0000 + {16'd0, r[15:0]};
    id   = rand_id();
    exp_q.push_back(ax_flit(AxiAr, '0, id, addr, 8'd0));
    send_ar(id, addr, 8'd0);
    compare_req_flits("test_addr_map");
  endtask

  task automatic test_no_interleave();
    axi_id_t   id;
    axi_addr_t rd_addr;
    axi_addr_t wr_addr;
    // A finished write hands round-robin priority to the AR input
    do_write(rand_region_addr(), 1);
    wr_addr = rand_region_addr();
    rd_addr = rand_region_addr();
    id      = rand_id();
    fork
      do_write(wr_addr, ShortBurst);
      begin
        // AR comes up once the burst holds the link
        @(posedge clk_i);
        while (!(aw_valid_i && aw_ready_o)) @(posedge clk_i);
        send_ar(id, rd_addr, 8'd1);
      end
    join
    exp_q.push_back(ax_flit(AxiAr, expected_node(rd_addr), id, rd_addr, 8'd1));
    compare_req_flits("test_no_interleave");
  endtask

  task automatic test_backpressure();
    floo_req_flit_t held;
    logic [31:0]    r;
    int unsigned    stall;
    r     = rand_bits(3);
    stall = 2 + r[2:0];
    @(negedge clk_i);
    floo_req_ready_i = 1'b0;
    fork
      do_write(rand_region_addr(), 3);
      begin
        @(posedge clk_i);
        while (!floo_req_valid_o) @(posedge clk_i);
        held = floo_req_o;
        repeat (stall) begin
          if (aw_ready_o || w_ready_o || ar_ready_o) begin
            note_failure("test_backpressure: an AXI ready rose while the link was stalled");
          end
          check_req_flit("test_backpressure", held, floo_req_o);
          @(posedge clk_i);
        end
        @(negedge clk_i);
        floo_req_ready_i = 1'b1;
      end
    join
    compare_req_flits("test_backpressure");
  endtask

  task automatic test_responses();
    floo_rsp_flit_t f;
    axi_id_t        id;
    axi_data_t      data;
    axi_resp_e      resp;
    logic           last;
    logic           is_b;
    logic           done;
    logic [31:0]    r;
    for (int k = 0; k < NumRsp; k++) begin
      id   = rand_id();
      data = rand_bits(32);
      resp = rand_resp();
      r    = rand_bits(1);
      last = r[0];
      is_b = (k % 2 == 0);
      f = '0;
      f.hdr.dst_id = TbId;
      f.hdr.src_id = NodeOf[k % NumRules];
      f.hdr.axi_ch = is_b ? AxiB : AxiR;
      f.hdr.last   = 1'b1;
      if (is_b) begin
        f.payload[5:0] = {id, resp};
      end else begin
        f.payload[38:0] = {id, data, resp, last};
      end
      done = 1'b0;
      while (!done) begin
        @(negedge clk_i);
        floo_rsp_valid_i = 1'b1;
        floo_rsp_i       = f;
        r = rand_bits(2);
        b_ready_i = r[0];
        r_ready_i = r[1];
        @(posedge clk_i);
        if (b_valid_o !== is_b || r_valid_o !== !is_b) begin
          note_failure("test_responses: the flit raised the wrong AXI response valid");
        end
        if (floo_rsp_ready_o !== (is_b ? b_ready_i : r_ready_i)) begin
          note_failure("test_responses: floo_rsp_ready_o does not follow the channel ready");
        end
        if (is_b) begin
          check_b("test_responses", id, resp, b_id_o, b_resp_o);
        end else begin
          check_r("test_responses", id, data, resp, last, r_id_o, r_data_o, r_resp_o, r_last_o);
        end
        done = floo_rsp_ready_o;
      end
    end
    @(negedge clk_i);
    floo_rsp_valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    id_i = TbId;
    aw_valid_i = 1'b0;
    aw_id_i    = '0;
    aw_addr_i  = '0;
    aw_len_i   = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    ar_valid_i = 1'b0;
    ar_id_i    = '0;
    ar_addr_i  = '0;
    ar_len_i   = '0;
    b_ready_i  = 1'b0;
    r_ready_i  = 1'b0;
    floo_req_ready_i = 1'b0;
    floo_rsp_valid_i = 1'b0;
    floo_rsp_i       = '0;
    wait (arst_n_i === 1'b1);
    @(negedge clk_i);
    if (floo_req_valid_o || b_valid_o || r_valid_o || aw_ready_o || w_ready_o || ar_ready_o) begin
      note_failure("A valid or ready output is high right after reset");
    end
    floo_req_ready_i = 1'b1;
    test_write_burst();
    test_read();
    test_addr_map();
    test_no_interleave();
    test_backpressure();
    test_responses();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+tb
hw/floo_axi_pkg.sv
hw/floo_noc_pkg.sv
hw/floo_addr_translation.sv
hw/floo_req_packer.sv
hw/floo_wormhole_arbiter.sv
hw/floo_rsp_unpacker.sv
hw/floo_axi_chimney.sv
tb/tb_clk_gen.sv
tb/tb_floo_axi_chimney.sv
